//--- hw/decode_pkg.sv
// Widths, encodings and the micro-op record shared by all blocks of the RV32I decode stage
package decode_pkg;

    localparam int XLEN       = 32;            // Data and PC width
    localparam int REG_ADDR_W = 5;
    localparam int INSTR_W    = 32;

    // Major opcodes of the kept RV32I subset
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,                        // Zero so a bubble is a harmless add
        ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU,
        ALU_PASS_B                             // LUI result is the immediate
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_cond_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0, MEM_HALF = 2'd1, MEM_WORD = 2'd2  // Same as funct3[1:0]
    } mem_size_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,                       // Register file value
        FWD_EXEC = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    typedef struct packed {
        alu_op_e      alu_op;
        logic         op1_is_pc;               // AUIPC, JAL
        logic         op2_is_imm;
        logic         writes_rd;
        logic         is_load;
        logic         is_store;
        mem_size_e    mem_size;
        logic         load_unsigned;
        branch_cond_e branch_cond;
        logic         is_jump;
        logic         is_jalr;
    } uop_t;

    localparam uop_t UOP_BUBBLE = '0;          // No writes, no memory access, no jump

endpackage

//--- hw/decode_if.sv
// Decoded instruction bundle passed from the decoder and immediate unit to the later decode blocks
`timescale 1ns/100ps

interface decode_if;

    decode_pkg::uop_t                  uop;
    logic [decode_pkg::XLEN-1:0]       imm;        // Sign-extended immediate
    logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [decode_pkg::REG_ADDR_W-1:0] rd_addr;
    logic                              illegal;    // Outside the kept set

    // Decoder drives all but imm, immediate unit drives imm
    modport producer (output uop, imm, rs1_addr, rs2_addr, rd_addr, illegal);

    modport consumer (input uop, imm, rs1_addr, rs2_addr, rd_addr, illegal);

endinterface

//--- hw/instr_decoder.sv
// Combinational RV32I decoder turning one instruction into a micro-op record and an illegal flag
`timescale 1ns/100ps

module instr_decoder (
    input  logic [decode_pkg::INSTR_W-1:0] instr_i,
    decode_if.producer                     dec
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             alt;              // funct7 selects SUB or SRA
    logic             f7_ok;            // funct7 is one of the two base values
    decode_pkg::uop_t uop;
    logic             illegal;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign alt    = (funct7 == 7'b0100000);
    assign f7_ok  = alt || (funct7 == 7'b0000000);

    function automatic decode_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'b001:  return decode_pkg::ALU_SLL;
            3'b010:  return decode_pkg::ALU_SLT;
            3'b011:  return decode_pkg::ALU_SLTU;
            3'b100:  return decode_pkg::ALU_XOR;
            3'b101:  return sub_sra ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'b110:  return decode_pkg::ALU_OR;
            default: return decode_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        uop     = decode_pkg::UOP_BUBBLE;
        illegal = 1'b0;
        case (opcode)
            decode_pkg::OPC_OP: begin
                // Alternate funct7 only exists for SUB and SRA
                illegal = !(funct7 == 7'b0 || (alt && (funct3 == 3'b000 || funct3 == 3'b101)));
                if (!illegal) begin
                    uop.alu_op    = alu_of(funct3, alt);
                    uop.writes_rd = 1'b1;
                end
            end
            decode_pkg::OPC_OP_IMM: begin
                illegal = (funct3 == 3'b001 && funct7 != 7'b0) || (funct3 == 3'b101 && !f7_ok);
                if (!illegal) begin
                    uop.alu_op     = alu_of(funct3, alt && funct3 == 3'b101);  // No SUBI
                    uop.op2_is_imm = 1'b1;
                    uop.writes_rd  = 1'b1;
                end
            end
            decode_pkg::OPC_LOAD: begin
                illegal = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
                if (!illegal) begin
                    uop.op2_is_imm    = 1'b1;                   // Address is rs1 + imm
                    uop.writes_rd     = 1'b1;
                    uop.is_load       = 1'b1;
                    uop.mem_size      = decode_pkg::mem_size_e'(funct3[1:0]);
                    uop.load_unsigned = funct3[2];
                end
            end
            decode_pkg::OPC_STORE: begin
                illegal = funct3[2] || (funct3[1:0] == 2'b11);
                if (!illegal) begin
                    uop.op2_is_imm = 1'b1;
                    uop.is_store   = 1'b1;
                    uop.mem_size   = decode_pkg::mem_size_e'(funct3[1:0]);
                end
            end
            decode_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000:  uop.branch_cond = decode_pkg::BR_EQ;
                    3'b001:  uop.branch_cond = decode_pkg::BR_NE;
                    3'b100:  uop.branch_cond = decode_pkg::BR_LT;
                    3'b101:  uop.branch_cond = decode_pkg::BR_GE;
                    3'b110:  uop.branch_cond = decode_pkg::BR_LTU;
                    3'b111:  uop.branch_cond = decode_pkg::BR_GEU;
                    default: illegal = 1'b1;
                endcase
                uop.op2_is_imm = !illegal;                      // Flags carry the compare
            end
            decode_pkg::OPC_JAL: begin
                uop.op1_is_pc  = 1'b1;
                uop.op2_is_imm = 1'b1;
                uop.writes_rd  = 1'b1;
                uop.is_jump    = 1'b1;
            end
            decode_pkg::OPC_JALR: begin
                illegal = (funct3 != 3'b000);
                if (!illegal) begin
                    uop.op2_is_imm = 1'b1;
                    uop.writes_rd  = 1'b1;
                    uop.is_jump    = 1'b1;
                    uop.is_jalr    = 1'b1;
                end
            end
            decode_pkg::OPC_LUI: begin
                uop.alu_op     = decode_pkg::ALU_PASS_B;
                uop.op2_is_imm = 1'b1;
                uop.writes_rd  = 1'b1;
            end
            decode_pkg::OPC_AUIPC: begin
                uop.op1_is_pc  = 1'b1;
                uop.op2_is_imm = 1'b1;
                uop.writes_rd  = 1'b1;
            end
            default: illegal = 1'b1;                            // FENCE, SYSTEM, extensions
        endcase
    end

    assign dec.uop      = uop;
    assign dec.illegal  = illegal;
    assign dec.rs1_addr = instr_i[19:15];
    assign dec.rs2_addr = instr_i[24:20];
    assign dec.rd_addr  = instr_i[11:7];

    // An illegal instruction must never reach issue with side effects
    a_illegal_bubble: assert final (!dec.illegal || dec.uop == decode_pkg::UOP_BUBBLE);

endmodule

//--- hw/imm_gen.sv
// Immediate generator picking the instruction format from the opcode and sign-extending it
`timescale 1ns/100ps

module imm_gen (
    input  logic [decode_pkg::INSTR_W-1:0] instr_i,
    decode_if.producer                     dec
);

    decode_pkg::imm_fmt_e fmt;
    logic                 s;                    // Sign bit

    assign s = instr_i[31];

    always_comb begin
        case (instr_i[6:0])
            decode_pkg::OPC_LOAD,
            decode_pkg::OPC_OP_IMM,
            decode_pkg::OPC_JALR:   fmt = decode_pkg::IMM_I;
            decode_pkg::OPC_STORE:  fmt = decode_pkg::IMM_S;
            decode_pkg::OPC_BRANCH: fmt = decode_pkg::IMM_B;
            decode_pkg::OPC_JAL:    fmt = decode_pkg::IMM_J;
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC:  fmt = decode_pkg::IMM_U;
            default:                fmt = decode_pkg::IMM_NONE;  // Register ops and unknown
        endcase
    end

    always_comb begin
        case (fmt)
            decode_pkg::IMM_I: dec.imm = {{20{s}}, instr_i[31:20]};
            decode_pkg::IMM_S: dec.imm = {{20{s}}, instr_i[31:25], instr_i[11:7]};
            decode_pkg::IMM_B: dec.imm = {{20{s}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            decode_pkg::IMM_U: dec.imm = {instr_i[31:12], 12'b0};
            decode_pkg::IMM_J: dec.imm = {{12{s}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            default:           dec.imm = '0;
        endcase
    end

endmodule

//--- hw/reg_file.sv
// Integer register file with two combinational read ports and one writeback write port
`timescale 1ns/100ps

module reg_file #(
    parameter int REG_COUNT = 32                  // 16 gives an RV32E-sized file
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    decode_if.consumer                        dec,
    output logic [decode_pkg::XLEN-1:0]       rs1_data_o,
    output logic [decode_pkg::XLEN-1:0]       rs2_data_o,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [decode_pkg::XLEN-1:0]       wb_data_i,
    input  logic                              wb_we_i
);

    logic [decode_pkg::XLEN-1:0] regs [1:REG_COUNT-1];  // x0 is not stored
    logic                        rs1_valid;
    logic                        rs2_valid;
    logic                        wb_valid;

    assign rs1_valid = (dec.rs1_addr != '0) && (dec.rs1_addr < REG_COUNT);
    assign rs2_valid = (dec.rs2_addr != '0) && (dec.rs2_addr < REG_COUNT);
    assign wb_valid  = (wb_addr_i != '0) && (wb_addr_i < REG_COUNT);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && wb_valid) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // Same-cycle write is not visible here, the WB forward covers it
    assign rs1_data_o = rs1_valid ? regs[dec.rs1_addr] : '0;
    assign rs2_data_o = rs2_valid ? regs[dec.rs2_addr] : '0;

    a_wb_addr_known: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) wb_we_i |-> !$isunknown(wb_addr_i)
    );

endmodule

//--- hw/operand_select.sv
// Operand selection with forwarding muxes, PC/immediate substitution and compare flags
`timescale 1ns/100ps

module operand_select (
    decode_if.consumer                  dec,
    input  logic [decode_pkg::XLEN-1:0] pc_i,
    input  logic [decode_pkg::XLEN-1:0] rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0] rs2_data_i,
    input  logic [decode_pkg::XLEN-1:0] exec_fwd_i,
    input  logic [decode_pkg::XLEN-1:0] wb_data_i,
    input  decode_pkg::fwd_sel_e        fwd_sel1_i,
    input  decode_pkg::fwd_sel_e        fwd_sel2_i,
    output logic [decode_pkg::XLEN-1:0] op1_o,
    output logic [decode_pkg::XLEN-1:0] op2_o,
    output logic                        lt_o,
    output logic                        ltu_o,
    output logic                        eq_o
);

    logic [decode_pkg::XLEN-1:0] rs1_val;    // After forwarding
    logic [decode_pkg::XLEN-1:0] rs2_val;

    function automatic logic [decode_pkg::XLEN-1:0] fwd_mux(
        input decode_pkg::fwd_sel_e        sel,
        input logic [decode_pkg::XLEN-1:0] rf_val,
        input logic [decode_pkg::XLEN-1:0] ex_val,
        input logic [decode_pkg::XLEN-1:0] wb_val
    );
        case (sel)
            decode_pkg::FWD_EXEC: return ex_val;
            decode_pkg::FWD_WB:   return wb_val;
            default:              return rf_val;  // Unused code reads the file too
        endcase
    endfunction

    assign rs1_val = fwd_mux(fwd_sel1_i, rs1_data_i, exec_fwd_i, wb_data_i);
    assign rs2_val = fwd_mux(fwd_sel2_i, rs2_data_i, exec_fwd_i, wb_data_i);

    assign op1_o = dec.uop.op1_is_pc  ? pc_i    : rs1_val;
    assign op2_o = dec.uop.op2_is_imm ? dec.imm : rs2_val;

    // Branch compares always use the register values
    assign lt_o  = $signed(rs1_val) < $signed(rs2_val);
    assign ltu_o = rs1_val < rs2_val;
    assign eq_o  = rs1_val == rs2_val;

endmodule

//--- hw/issue_reg.sv
// Issue register handing the decoded instruction and operands to execute, with stall and flush
`timescale 1ns/100ps

module issue_reg (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              stall_i,
    input  logic                              flush_i,
    decode_if.consumer                        dec,
    input  logic [decode_pkg::XLEN-1:0]       op1_i,
    input  logic [decode_pkg::XLEN-1:0]       op2_i,
    input  logic [decode_pkg::XLEN-1:0]       pc_plus4_i,
    input  logic                              lt_i,
    input  logic                              ltu_i,
    input  logic                              eq_i,
    output decode_pkg::uop_t                  ex_uop_o,
    output logic [decode_pkg::XLEN-1:0]       ex_op1_o,
    output logic [decode_pkg::XLEN-1:0]       ex_op2_o,
    output logic [decode_pkg::XLEN-1:0]       ex_pc_plus4_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] ex_rd_addr_o,
    output logic [2:0]                        ex_flags_o      // {lt, ltu, eq}
);

    logic bubble;                                  // Load a bubble this edge

    assign bubble = flush_i || (!stall_i && dec.illegal);  // Flush wins over stall

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_uop_o      <= decode_pkg::UOP_BUBBLE;
            ex_op1_o      <= '0;
            ex_op2_o      <= '0;
            ex_pc_plus4_o <= '0;
            ex_rd_addr_o  <= '0;
            ex_flags_o    <= '0;
        end else if (bubble) begin
            ex_uop_o      <= decode_pkg::UOP_BUBBLE;
            ex_op1_o      <= '0;
            ex_op2_o      <= '0;
            ex_pc_plus4_o <= '0;
            ex_rd_addr_o  <= '0;
            ex_flags_o    <= '0;
        end else if (!stall_i) begin
            ex_uop_o      <= dec.uop;
            ex_op1_o      <= op1_i;
            ex_op2_o      <= op2_i;
            ex_pc_plus4_o <= pc_plus4_i;
            ex_rd_addr_o  <= dec.rd_addr;
            ex_flags_o    <= {lt_i, ltu_i, eq_i};
        end
    end

    a_flush_bubble: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) flush_i |=> ex_uop_o == decode_pkg::UOP_BUBBLE
    );

endmodule

//--- hw/decode_stage.sv
// Top of the RV32I decode stage, linking decoder, register file, operand muxes and issue register
`timescale 1ns/100ps

module decode_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic [decode_pkg::INSTR_W-1:0]    instr_i,
    input  logic [decode_pkg::XLEN-1:0]       pc_i,
    input  logic [decode_pkg::XLEN-1:0]       pc_plus4_i,
    input  logic [decode_pkg::XLEN-1:0]       exec_fwd_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [decode_pkg::XLEN-1:0]       wb_data_i,
    input  logic                              wb_we_i,
    input  logic                              stall_i,
    input  logic                              flush_i,
    input  decode_pkg::fwd_sel_e              fwd_sel1_i,
    input  decode_pkg::fwd_sel_e              fwd_sel2_i,
    output decode_pkg::uop_t                  ex_uop_o,
    output logic [decode_pkg::XLEN-1:0]       ex_op1_o,
    output logic [decode_pkg::XLEN-1:0]       ex_op2_o,
    output logic [decode_pkg::XLEN-1:0]       ex_pc_plus4_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] ex_rd_addr_o,
    output logic [2:0]                        ex_flags_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,     // To hazard unit
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic                              illegal_o
);

    decode_if dec_bus ();

    logic [decode_pkg::XLEN-1:0] rs1_data;
    logic [decode_pkg::XLEN-1:0] rs2_data;
    logic [decode_pkg::XLEN-1:0] op1;
    logic [decode_pkg::XLEN-1:0] op2;
    logic                        lt;
    logic                        ltu;
    logic                        eq;

    instr_decoder u_decoder (.instr_i(instr_i), .dec(dec_bus));

    imm_gen u_imm (.instr_i(instr_i), .dec(dec_bus));

    reg_file #(.REG_COUNT(REG_COUNT)) u_rf (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .dec(dec_bus),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i), .wb_we_i(wb_we_i)
    );

    operand_select u_opsel (
        .dec(dec_bus), .pc_i(pc_i), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .exec_fwd_i(exec_fwd_i), .wb_data_i(wb_data_i),
        .fwd_sel1_i(fwd_sel1_i), .fwd_sel2_i(fwd_sel2_i),
        .op1_o(op1), .op2_o(op2), .lt_o(lt), .ltu_o(ltu), .eq_o(eq)
    );

    issue_reg u_issue (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(stall_i), .flush_i(flush_i),
        .dec(dec_bus), .op1_i(op1), .op2_i(op2), .pc_plus4_i(pc_plus4_i),
        .lt_i(lt), .ltu_i(ltu), .eq_i(eq),
        .ex_uop_o(ex_uop_o), .ex_op1_o(ex_op1_o), .ex_op2_o(ex_op2_o),
        .ex_pc_plus4_o(ex_pc_plus4_o), .ex_rd_addr_o(ex_rd_addr_o), .ex_flags_o(ex_flags_o)
    );

    assign rs1_addr_o = dec_bus.rs1_addr;      // Same-cycle, for the hazard unit
    assign rs2_addr_o = dec_bus.rs2_addr;
    assign illegal_o  = dec_bus.illegal;

endmodule

//--- testbench/tb_decode_stage.sv
// Directed testbench for the decode stage, compiled with files.f and run with tb_decode_stage as top
`timescale 1ns/100ps

module tb_decode_stage;

    localparam int CLK_PERIOD = 40;

    logic                 clk_i;
    logic                 arst_n_i;
    logic [31:0]          instr_i;
    logic [31:0]          pc_i;
    logic [31:0]          pc_plus4_i;
    logic [31:0]          exec_fwd_i;
    logic [4:0]           wb_addr_i;
    logic [31:0]          wb_data_i;
    logic                 wb_we_i;
    logic                 stall_i;
    logic                 flush_i;
    decode_pkg::fwd_sel_e fwd_sel1_i;
    decode_pkg::fwd_sel_e fwd_sel2_i;
    decode_pkg::uop_t     ex_uop_o;
    logic [31:0]          ex_op1_o;
    logic [31:0]          ex_op2_o;
    logic [31:0]          ex_pc_plus4_o;
    logic [4:0]           ex_rd_addr_o;
    logic [2:0]           ex_flags_o;
    logic [4:0]           rs1_addr_o;
    logic [4:0]           rs2_addr_o;
    logic                 illegal_o;

    logic [31:0] model_regs [0:31];       // Expected register file contents
    int          errors;
    int          timeouts;
    integer      seed;

    decode_stage #(.REG_COUNT(32)) uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic finish_run();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // Polls for the next falling edge, gives up after two clock periods
    task automatic next_fall();
        int waited;
        waited = 0;
        while (clk_i !== 1'b1 && waited < CLK_PERIOD) begin
            #1;
            waited++;
        end
        while (clk_i !== 1'b0 && waited < 2 * CLK_PERIOD) begin
            #1;
            waited++;
        end
        if (clk_i !== 1'b0) begin
            $display("Timeout at %0t: no falling clock edge seen", $time);
            timeouts++;
            finish_run();
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, decode_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], decode_pkg::OPC_STORE};    // SW
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], decode_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, decode_pkg::OPC_JAL};
    endfunction

    // ALU op back to {funct7 alternate bit, funct3}
    function automatic logic [3:0] funct_of(decode_pkg::alu_op_e op);
        case (op)
            decode_pkg::ALU_SUB:  return 4'b1_000;
            decode_pkg::ALU_SLL:  return 4'b0_001;
            decode_pkg::ALU_SLT:  return 4'b0_010;
            decode_pkg::ALU_SLTU: return 4'b0_011;
            decode_pkg::ALU_XOR:  return 4'b0_100;
            decode_pkg::ALU_SRL:  return 4'b0_101;
            decode_pkg::ALU_SRA:  return 4'b1_101;
            decode_pkg::ALU_OR:   return 4'b0_110;
            decode_pkg::ALU_AND:  return 4'b0_111;
            default:              return 4'b0_000;
        endcase
    endfunction

    function automatic decode_pkg::uop_t alu_uop(decode_pkg::alu_op_e op, logic use_imm);
        decode_pkg::uop_t u;
        u            = decode_pkg::UOP_BUBBLE;
        u.alu_op     = op;
        u.op2_is_imm = use_imm;
        u.writes_rd  = 1'b1;
        return u;
    endfunction

    function automatic logic [31:0] fwd_value(decode_pkg::fwd_sel_e sel, logic [31:0] rf_val);
        if (sel == decode_pkg::FWD_EXEC) begin
            return exec_fwd_i;
        end else if (sel == decode_pkg::FWD_WB) begin
            return wb_data_i;
        end
        return rf_val;
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        wb_addr_i = addr;
        wb_data_i = data;
        wb_we_i   = 1'b1;
        next_fall();
        wb_we_i = 1'b0;
        if (addr != 5'd0) begin
            model_regs[addr] = data;            // x0 stays zero
        end
    endtask

    task automatic expect_bubble();
        check_val("ex_uop_o", ex_uop_o, decode_pkg::UOP_BUBBLE);
        check_val("ex_op1_o", ex_op1_o, '0);
        check_val("ex_op2_o", ex_op2_o, '0);
        check_val("ex_pc_plus4_o", ex_pc_plus4_o, '0);
        check_val("ex_rd_addr_o", ex_rd_addr_o, '0);
        check_val("ex_flags_o", ex_flags_o, '0);
    endtask

    task automatic issue_and_check(input logic [31:0] instr, input logic [31:0] pc,
                                   input decode_pkg::uop_t exp_uop, input logic [31:0] exp_imm);
        logic [31:0] a;
        logic [31:0] b;
        a = fwd_value(fwd_sel1_i, model_regs[instr[19:15]]);
        b = fwd_value(fwd_sel2_i, model_regs[instr[24:20]]);
        instr_i    = instr;
        pc_i       = pc;
        pc_plus4_i = pc + 32'd4;
        next_fall();
        check_val("illegal_o", illegal_o, 1'b0);
        check_val("rs1_addr_o", rs1_addr_o, instr[19:15]);
        check_val("rs2_addr_o", rs2_addr_o, instr[24:20]);
        check_val("ex_uop_o", ex_uop_o, exp_uop);
        check_val("ex_op1_o", ex_op1_o, exp_uop.op1_is_pc ? pc : a);
        check_val("ex_op2_o", ex_op2_o, exp_uop.op2_is_imm ? exp_imm : b);
        check_val("ex_pc_plus4_o", ex_pc_plus4_o, pc + 32'd4);
        check_val("ex_rd_addr_o", ex_rd_addr_o, instr[11:7]);
        check_val("ex_flags_o", ex_flags_o, {$signed(a) < $signed(b), a < b, a == b});
    endtask

    task automatic test_reset_stall_flush();
        logic [31:0] held [0:4];
        expect_bubble();                        // Straight out of reset
        write_reg(5'd1, 32'h0000_00a5);
        issue_and_check(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd3), 32'h100,
                        alu_uop(decode_pkg::ALU_ADD, 1'b0), '0);
        held = '{ex_uop_o, ex_op1_o, ex_op2_o, ex_pc_plus4_o, ex_flags_o};
        stall_i    = 1'b1;
        instr_i    = enc_i(12'd7, 5'd0, 3'b000, 5'd5, decode_pkg::OPC_OP_IMM);
        pc_i       = 32'h200;
        pc_plus4_i = 32'h204;
        next_fall();
        check_val("ex_uop_o", ex_uop_o, held[0]);
        check_val("ex_op1_o", ex_op1_o, held[1]);
        check_val("ex_op2_o", ex_op2_o, held[2]);
        check_val("ex_pc_plus4_o", ex_pc_plus4_o, held[3]);
        check_val("ex_flags_o", ex_flags_o, held[4]);
        check_val("ex_rd_addr_o", ex_rd_addr_o, 5'd3);
        flush_i = 1'b1;                         // Stall still high
        next_fall();
        expect_bubble();
        flush_i = 1'b0;
        stall_i = 1'b0;
    endtask

    task automatic test_reg_ops();
        write_reg(5'd1, 32'h0000_1234);
        write_reg(5'd2, 32'hffff_fff0);
        write_reg(5'd0, 32'hdead_beef);
        issue_and_check(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 32'h200,
                        alu_uop(decode_pkg::ALU_ADD, 1'b0), '0);
        issue_and_check(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd4), 32'h204,
                        alu_uop(decode_pkg::ALU_SUB, 1'b0), '0);
        issue_and_check(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd5), 32'h208,
                        alu_uop(decode_pkg::ALU_SLTU, 1'b0), '0);
        issue_and_check(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd6), 32'h20c,
                        alu_uop(decode_pkg::ALU_ADD, 1'b0), '0);
    endtask

    task automatic test_immediates();
        decode_pkg::uop_t u;
        logic [31:0]      pc;
        pc = 32'h0000_3000;
        u  = alu_uop(decode_pkg::ALU_ADD, 1'b1);
        issue_and_check(enc_i(12'hffb, 5'd1, 3'b000, 5'd7, decode_pkg::OPC_OP_IMM), pc, u,
                        32'hffff_fffb);
        u.is_load  = 1'b1;
        u.mem_size = decode_pkg::MEM_WORD;
        issue_and_check(enc_i(12'd12, 5'd2, 3'b010, 5'd8, decode_pkg::OPC_LOAD), pc, u, 32'd12);
        u.mem_size      = decode_pkg::MEM_BYTE;
        u.load_unsigned = 1'b1;                 // LBU
        issue_and_check(enc_i(12'h800, 5'd1, 3'b100, 5'd9, decode_pkg::OPC_LOAD), pc, u,
                        32'hffff_f800);
        u            = decode_pkg::UOP_BUBBLE;
        u.op2_is_imm = 1'b1;
        u.is_store   = 1'b1;
        u.mem_size   = decode_pkg::MEM_WORD;
        issue_and_check(enc_s(12'hff8, 5'd2, 5'd1), pc, u, 32'hffff_fff8);
        u             = decode_pkg::UOP_BUBBLE;
        u.op2_is_imm  = 1'b1;
        u.branch_cond = decode_pkg::BR_EQ;
        issue_and_check(enc_b(13'h1ff0, 5'd2, 5'd1), pc, u, 32'hffff_fff0);
        issue_and_check(enc_b(13'h0a54, 5'd2, 5'd1), pc, u, 32'h0000_0a54);
        issue_and_check({20'habcde, 5'd9, decode_pkg::OPC_LUI}, pc,
                        alu_uop(decode_pkg::ALU_PASS_B, 1'b1), 32'habcd_e000);
        u           = alu_uop(decode_pkg::ALU_ADD, 1'b1);
        u.op1_is_pc = 1'b1;
        issue_and_check({20'h12345, 5'd10, decode_pkg::OPC_AUIPC}, pc, u, 32'h1234_5000);
        u.is_jump = 1'b1;                       // JAL
        issue_and_check(enc_j(21'h1ff800, 5'd1), pc, u, 32'hffff_f800);
        issue_and_check(enc_j(21'h0abcd6, 5'd1), pc, u, 32'h000a_bcd6);
        u.op1_is_pc = 1'b0;
        u.is_jalr   = 1'b1;
        issue_and_check(enc_i(12'd100, 5'd2, 3'b000, 5'd1, decode_pkg::OPC_JALR), pc, u, 32'd100);
    endtask

    task automatic test_forwarding();
        write_reg(5'd11, 32'h0000_0005);
        write_reg(5'd12, 32'h8000_0005);        // Differs from x11 only in bit 31
        exec_fwd_i = 32'h8000_0005;
        wb_data_i  = 32'h0000_0005;
        for (int i = 0; i < 4; i++) begin       // Code 3 must read the register file
            for (int j = 0; j < 4; j++) begin
                fwd_sel1_i = decode_pkg::fwd_sel_e'(i[1:0]);
                fwd_sel2_i = decode_pkg::fwd_sel_e'(j[1:0]);
                issue_and_check(enc_r(7'h20, 5'd12, 5'd11, 3'b000, 5'd13), 32'h400,
                                alu_uop(decode_pkg::ALU_SUB, 1'b0), '0);
            end
        end
        fwd_sel1_i = decode_pkg::FWD_NONE;
        fwd_sel2_i = decode_pkg::FWD_NONE;
    endtask

    task automatic test_illegal();
        logic [31:0] bad [0:3];
        bad = '{32'h0000_007f, enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3), 32'h0ff0_000f,
                32'h0000_0073};                 // Unknown, MUL, FENCE, ECALL
        foreach (bad[k]) begin
            issue_and_check(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 32'h500,
                            alu_uop(decode_pkg::ALU_ADD, 1'b0), '0);
            instr_i = bad[k];
            #(CLK_PERIOD / 8);                  // Settle, still before the rising edge
            check_val("illegal_o", illegal_o, 1'b1);
            next_fall();
            expect_bubble();
        end
    endtask

    task automatic test_random();
        decode_pkg::alu_op_e op;
        logic [3:0]          fn;
        logic                use_imm;
        logic [4:0]          rs1;
        logic [11:0]         imm12;
        logic [31:0]         instr;
        for (int n = 0; n < 50; n++) begin
            rs1 = 5'($random(seed));
            write_reg(rs1, $random(seed));
            write_reg(5'($random(seed)), $random(seed));
            exec_fwd_i = $random(seed);
            wb_data_i  = $random(seed);
            fwd_sel1_i = decode_pkg::fwd_sel_e'(2'($unsigned($random(seed)) % 3));
            fwd_sel2_i = decode_pkg::fwd_sel_e'(2'($unsigned($random(seed)) % 3));
            op      = decode_pkg::alu_op_e'(4'($unsigned($random(seed)) % 10));
            use_imm = 1'($random(seed));
            imm12   = 12'($random(seed));
            if (use_imm && op == decode_pkg::ALU_SUB) begin
                op = decode_pkg::ALU_ADD;       // No SUBI
            end
            fn = funct_of(op);
            if (!use_imm) begin
                instr = enc_r({1'b0, fn[3], 5'b0}, 5'($random(seed)), rs1, fn[2:0],
                              5'($random(seed)));
            end else begin
                if (fn[1:0] == 2'b01) begin
                    imm12 = {1'b0, fn[3], 5'b0, imm12[4:0]};  // Shift amount form
                end
                instr = enc_i(imm12, rs1, fn[2:0], 5'($random(seed)), decode_pkg::OPC_OP_IMM);
            end
            issue_and_check(instr, 32'($random(seed)) & 32'hffff_fffc, alu_uop(op, use_imm),
                            {{20{imm12[11]}}, imm12});
        end
    endtask

    initial begin
        errors     = 0;
        timeouts   = 0;
        seed       = 32'hc35f;
        arst_n_i   = 1'b0;
        instr_i    = 32'h0000_0013;             // NOP
        pc_i       = '0;
        pc_plus4_i = '0;
        exec_fwd_i = '0;
        wb_addr_i  = '0;
        wb_data_i  = '0;
        wb_we_i    = 1'b0;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        fwd_sel1_i = decode_pkg::FWD_NONE;
        fwd_sel2_i = decode_pkg::FWD_NONE;
        foreach (model_regs[r]) begin
            model_regs[r] = '0;
        end
        repeat (5) next_fall();
        arst_n_i = 1'b1;
        test_reset_stall_flush();
        test_reg_ops();
        test_immediates();
        test_forwarding();
        test_illegal();
        test_random();
        finish_run();
    end

endmodule

//--- files.f
hw/decode_pkg.sv
hw/decode_if.sv
hw/instr_decoder.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/operand_select.sv
hw/issue_reg.sv
hw/decode_stage.sv
testbench/tb_decode_stage.sv
